// ==== logic/uart_loopback_top.sv ====
module uart_loopback_top #(
	parameter int CLKS_PER_BIT = 8, // clocks per serial bit
	parameter bit PARITY_EN    = 1'b1, // parity bit sent and checked
	parameter bit PARITY_ODD   = 1'b0 // 0 even, 1 odd
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_send, // send strobe
	input  logic [uart_pkg::DATA_W-1:0] i_tx_data,
	input  logic                        i_loopback, // 1 feeds tx back into rx
	input  logic                        i_serial_in, // external line
	output logic                        o_serial_out,
	output logic                        o_busy,
	output logic                        o_rx_valid,
	output uart_pkg::rx_word_t          o_rx_word
);

	logic rx_line; // line seen by the receiver

	// loopback select, external line used for injected frames
	assign rx_line = i_loopback ? o_serial_out : i_serial_in;

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.PARITY_EN    (PARITY_EN),
		.PARITY_ODD   (PARITY_ODD)
	) uart_tx_inst (
		.clk          (clk),
		.reset        (reset),
		.i_send       (i_send),
		.i_tx_data    (i_tx_data),
		.o_serial_out (o_serial_out),
		.o_busy       (o_busy)
	);

	uart_rx #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.PARITY_EN    (PARITY_EN),
		.PARITY_ODD   (PARITY_ODD)
	) uart_rx_inst (
		.clk          (clk),
		.reset        (reset),
		.i_serial_in  (rx_line),
		.o_rx_valid   (o_rx_valid),
		.o_rx_word    (o_rx_word)
	);

endmodule

// ==== logic/uart_pkg.sv ====
package uart_pkg;

	localparam int DATA_W = 8; // data bits per frame

	// transmitter FSM, one state per frame section
	typedef enum logic [2:0] {
		TX_IDLE   = 3'd0, // line held high, waiting for send
		TX_START  = 3'd1, // start bit, line low
		TX_DATA   = 3'd2, // data bits lsb first
		TX_PARITY = 3'd3, // only visited when parity is enabled
		TX_STOP   = 3'd4  // stop bit, line high
	} tx_state_t;

	// receiver FSM, mirrors the frame layout
	typedef enum logic [2:0] {
		RX_IDLE   = 3'd0, // waiting for a falling edge
		RX_START  = 3'd1, // half-bit check of the start bit
		RX_DATA   = 3'd2, // mid-bit sampling of data bits
		RX_PARITY = 3'd3, // parity sample
		RX_STOP   = 3'd4  // stop sample, word is reported here
	} rx_state_t;

	// received word as reported with the valid pulse, 10 bits in total
	typedef struct packed {
		logic [DATA_W-1:0] data; // payload, bit 0 came first on the line
		logic              parity_err; // received parity differs from computed
		logic              stop_err; // stop bit sampled low
	} rx_word_t;

endpackage

// ==== logic/uart_rx.sv ====
module uart_rx #(
	parameter int CLKS_PER_BIT = 8, // clocks per serial bit, 4 or more
	parameter bit PARITY_EN    = 1'b1, // 1 expects a parity bit
	parameter bit PARITY_ODD   = 1'b0 // 0 even, 1 odd
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               i_serial_in, // asynchronous serial line
	output logic               o_rx_valid, // one-cycle pulse per frame
	output uart_pkg::rx_word_t o_rx_word
);
	import uart_pkg::*;

	localparam int TIMER_W  = $clog2(CLKS_PER_BIT);
	localparam int INDEX_W  = $clog2(DATA_W);
	localparam int HALF_BIT = CLKS_PER_BIT / 2;

	logic [2:0]         sync_q; // three-stage synchronizer
	logic               line_q; // synchronized line one clock earlier
	logic               rx_line; // synchronized line
	logic               start_edge; // high-to-low on the synchronized line
	logic               sample; // timer expired, sample point
	rx_state_t          state;
	logic [TIMER_W-1:0] timer; // counts down to the next sample point
	logic [INDEX_W-1:0] bit_idx; // data bit being sampled
	logic [DATA_W-1:0]  shift_q; // data collected lsb first
	logic               parity_acc; // expected parity, built bit by bit
	logic               parity_err_q; // result of the parity sample

	assign rx_line    = sync_q[2];
	assign start_edge = line_q && !rx_line;
	assign sample     = (timer == '0);

	// line synchronizer, starts high so reset does not look like a start bit
	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q <= '1;
			line_q <= 1'b1;
		end else begin
			sync_q <= {sync_q[1:0], i_serial_in};
			line_q <= rx_line;
		end
	end

	// payload collection on sample points
	always_ff @(posedge clk) begin
		if (state == RX_START && sample) begin
			parity_acc   <= PARITY_ODD; // odd parity starts from one
			parity_err_q <= 1'b0; // stays clear when parity is off
		end else if (state == RX_DATA && sample) begin
			shift_q    <= {rx_line, shift_q[DATA_W-1:1]}; // first bit ends in bit 0
			parity_acc <= parity_acc ^ rx_line;
		end else if (state == RX_PARITY && sample) begin
			parity_err_q <= parity_acc ^ rx_line;
		end
		if (state == RX_STOP && sample) begin
			o_rx_word.data       <= shift_q;
			o_rx_word.parity_err <= parity_err_q;
			o_rx_word.stop_err   <= !rx_line; // framing error on a low stop bit
		end
	end

	// receive FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= RX_IDLE;
			timer      <= '0;
			bit_idx    <= '0;
			o_rx_valid <= 1'b0;
		end else begin
			o_rx_valid <= 1'b0; // pulse by default off
			if (state != RX_IDLE && !sample) begin
				timer <= timer - 1'b1;
			end
			case (state)
				RX_IDLE: begin
					if (start_edge) begin
						state <= RX_START;
						timer <= TIMER_W'(HALF_BIT - 1); // middle of the start bit
					end
				end
				RX_START: begin
					if (sample) begin
						if (!rx_line) begin
							state   <= RX_DATA;
							timer   <= TIMER_W'(CLKS_PER_BIT - 1);
							bit_idx <= '0;
						end else begin
							state <= RX_IDLE; // glitch shorter than half a bit
						end
					end
				end
				RX_DATA: begin
					if (sample) begin
						timer <= TIMER_W'(CLKS_PER_BIT - 1);
						if (bit_idx == INDEX_W'(DATA_W - 1)) begin
							state <= PARITY_EN ? RX_PARITY : RX_STOP;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				RX_PARITY: begin
					if (sample) begin
						state <= RX_STOP;
						timer <= TIMER_W'(CLKS_PER_BIT - 1);
					end
				end
				RX_STOP: begin
					if (sample) begin
						state      <= RX_IDLE; // next edge may follow mid stop bit
						o_rx_valid <= 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	a_valid_single_cycle: assert property (@(posedge clk) disable iff (reset)
		o_rx_valid |=> !o_rx_valid);

	// valid is registered, so the stop state is one clock back
	a_valid_from_stop: assert property (@(posedge clk) disable iff (reset)
		$rose(o_rx_valid) |-> $past(state) == RX_STOP);

	a_state_legal: assert property (@(posedge clk) disable iff (reset)
		state inside {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP});

endmodule

// ==== logic/uart_tx.sv ====
module uart_tx #(
	parameter int CLKS_PER_BIT = 8, // clocks per serial bit, 4 or more
	parameter bit PARITY_EN    = 1'b1, // 1 adds a parity bit to the frame
	parameter bit PARITY_ODD   = 1'b0 // 0 even, 1 odd
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_send, // one-cycle send strobe
	input  logic [uart_pkg::DATA_W-1:0] i_tx_data,
	output logic                        o_serial_out,
	output logic                        o_busy
);
	import uart_pkg::*;

	localparam int TIMER_W = $clog2(CLKS_PER_BIT);
	localparam int INDEX_W = $clog2(DATA_W);

	tx_state_t          state;
	logic [TIMER_W-1:0] bit_timer; // cycles spent in the current bit
	logic [INDEX_W-1:0] bit_idx; // data bit on the line
	logic [DATA_W-1:0]  shift_q; // captured word, shifted right per data bit
	logic               parity_q; // parity of the captured word
	logic               bit_done; // last cycle of the current bit
	logic               accept; // send taken on this clock

	assign bit_done = (bit_timer == TIMER_W'(CLKS_PER_BIT - 1));
	assign accept   = i_send && !o_busy; // a send while busy is dropped

	// payload capture and shifting
	always_ff @(posedge clk) begin
		if (accept) begin
			shift_q  <= i_tx_data;
			parity_q <= (^i_tx_data) ^ PARITY_ODD; // inverted for odd parity
		end else if (state == TX_DATA && bit_done) begin
			shift_q <= shift_q >> 1; // next data bit moves to bit 0
		end
	end

	// frame FSM, line and busy are registered so they change on bit edges
	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= TX_IDLE;
			bit_timer    <= '0;
			bit_idx      <= '0;
			o_serial_out <= 1'b1; // idle line is high
			o_busy       <= 1'b0;
		end else begin
			if (state != TX_IDLE) begin
				bit_timer <= bit_done ? '0 : bit_timer + 1'b1;
			end
			case (state)
				TX_IDLE: begin
					if (accept) begin
						state        <= TX_START;
						bit_timer    <= '0; // bit timing restarts on each send
						bit_idx      <= '0;
						o_serial_out <= 1'b0; // start bit on the next clock
						o_busy       <= 1'b1;
					end
				end
				TX_START: begin
					if (bit_done) begin
						state        <= TX_DATA;
						o_serial_out <= shift_q[0]; // lsb first
					end
				end
				TX_DATA: begin
					if (bit_done) begin
						if (bit_idx == INDEX_W'(DATA_W - 1)) begin
							if (PARITY_EN) begin
								state        <= TX_PARITY;
								o_serial_out <= parity_q;
							end else begin
								state        <= TX_STOP; // no parity bit in this frame
								o_serial_out <= 1'b1;
							end
						end else begin
							bit_idx      <= bit_idx + 1'b1;
							o_serial_out <= shift_q[1]; // bit 0 shifts out on this clock
						end
					end
				end
				TX_PARITY: begin
					if (bit_done) begin
						state        <= TX_STOP;
						o_serial_out <= 1'b1; // stop bit
					end
				end
				TX_STOP: begin
					if (bit_done) begin
						state  <= TX_IDLE; // new send may be taken on the next clock
						o_busy <= 1'b0;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	a_idle_line_high: assert property (@(posedge clk) disable iff (reset)
		(state == TX_IDLE) |-> o_serial_out);

	a_busy_tracks_state: assert property (@(posedge clk) disable iff (reset)
		o_busy == (state != TX_IDLE));

	a_timer_in_range: assert property (@(posedge clk) disable iff (reset)
		bit_timer < CLKS_PER_BIT);

endmodule

// ==== project.f ====
logic/uart_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_loopback_top.sv
test/uart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the uart loopback testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module uart_tb -f project.f -o uart_tb_sim
# the log decides the result, so a failing run must not stop the script here
./obj_dir/uart_tb_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "sim failed" sim.log; then
	echo "result: FAIL"
	exit 1
fi
if ! grep -q "sim passed" sim.log; then
	echo "result: no pass line in sim.log"
	exit 1
fi
echo "result: PASS"

// ==== test/uart_tb.sv ====
module uart_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import uart_pkg::*;

	localparam int CLKS_PER_BIT = 8; // tb copy, overrides the top level
	localparam bit PARITY_EN    = 1'b1;
	localparam bit PARITY_ODD   = 1'b0; // even parity
	localparam int FRAME_BITS   = DATA_W + int'(PARITY_EN) + 2; // start, data, parity, stop
	localparam int FRAME_CLKS   = FRAME_BITS * CLKS_PER_BIT;
	localparam int HALF_BIT     = CLKS_PER_BIT / 2;
	localparam int GLITCH_CLKS  = 3; // shorter than half a bit
	localparam int RESET_CLKS   = 16;

	logic              clk = 1'b0;
	logic              reset;
	logic              i_send;
	logic [DATA_W-1:0] i_tx_data;
	logic              i_loopback;
	logic              i_serial_in;
	logic              o_serial_out;
	logic              o_busy;
	logic              o_rx_valid;
	rx_word_t          o_rx_word;

	int unsigned lcg_state = 32'd24327; // idle gap generator state
	int          rx_count; // valid pulses seen since the last step
	rx_word_t    rx_last; // word of the latest valid pulse

	always #20 clk = ~clk; // 40 ns period

	uart_loopback_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.PARITY_EN    (PARITY_EN),
		.PARITY_ODD   (PARITY_ODD)
	) uart_loopback_top_inst (
		.clk          (clk),
		.reset        (reset),
		.i_send       (i_send),
		.i_tx_data    (i_tx_data),
		.i_loopback   (i_loopback),
		.i_serial_in  (i_serial_in),
		.o_serial_out (o_serial_out),
		.o_busy       (o_busy),
		.o_rx_valid   (o_rx_valid),
		.o_rx_word    (o_rx_word)
	);

	function automatic int unsigned next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16; // upper bits are the better ones
	endfunction

	// line levels of one frame, index 0 goes out first
	function automatic logic [FRAME_BITS-1:0] build_frame(input logic [DATA_W-1:0] data,
			input logic flip, input logic stop_bit);
		logic [FRAME_BITS-1:0] bits;
		logic                  parity;
		int                    i;
		parity  = PARITY_ODD;
		bits[0] = 1'b0; // start bit
		for (i = 0; i < DATA_W; i++) begin
			parity      ^= data[i];
			bits[i + 1]  = data[i]; // lsb first
		end
		if (PARITY_EN) begin
			bits[DATA_W + 1] = parity ^ flip; // flip injects a parity error
		end
		bits[FRAME_BITS - 1] = stop_bit;
		return bits;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			abort_run($sformatf("Mismatch at %0d ns: %s, got %0h, expected %0h", $time, what,
				actual, expected));
		end
	endtask

	// one clock, sampled at the falling edge where outputs are stable
	task automatic tick();
		@(negedge clk);
		if (o_rx_valid) begin
			rx_count++;
			rx_last = o_rx_word;
		end
	endtask

	task automatic check_idle_outputs(input string when);
		check_value(32'(o_serial_out), 32'd1, {"serial out ", when});
		check_value(32'(o_busy), 32'd0, {"busy ", when});
		check_value(32'(o_rx_valid), 32'd0, {"rx valid ", when});
	endtask

	task automatic check_word(input logic [DATA_W-1:0] exp_data, input logic exp_perr,
			input logic exp_serr);
		check_value(32'(rx_count), 32'd1, "words received in this step");
		check_value(32'(rx_last.data), 32'(exp_data), "received data");
		check_value(32'(rx_last.parity_err), 32'(exp_perr), "parity error flag");
		check_value(32'(rx_last.stop_err), 32'(exp_serr), "stop error flag");
		rx_count = 0;
	endtask

	task automatic wait_busy_low(input int limit);
		int n;
		n = 0;
		while (o_busy) begin
			if (n == limit) abort_run("timeout waiting for the transmitter to go idle");
			else begin
				tick();
				n++;
			end
		end
	endtask

	task automatic wait_rx_word(input int limit);
		int n;
		n = 0;
		while (rx_count == 0) begin
			if (n == limit) abort_run("timeout waiting for a received word");
			else begin
				tick();
				n++;
			end
		end
	endtask

	task automatic run_loopback_step(input logic [DATA_W-1:0] data,
			input logic [DATA_W-1:0] exp_data, input logic exp_perr, input logic exp_serr);
		logic [FRAME_BITS-1:0] bits;
		int                    cyc;
		bits = build_frame(data, 1'b0, 1'b1);
		wait_busy_low(FRAME_CLKS);
		i_loopback  = 1'b1;
		i_serial_in = 1'b1;
		i_tx_data   = data;
		i_send      = 1'b1;
		tick(); // accepting clock, offset 0 from here
		i_send    = 1'b0;
		i_tx_data = ~data; // payload of the send that must be ignored
		check_value(32'(o_busy), 32'd1, "busy after accepted send");
		for (cyc = 1; cyc < FRAME_CLKS; cyc++) begin
			i_send = (cyc == CLKS_PER_BIT + 2); // strobe while busy
			tick();
			if (cyc % CLKS_PER_BIT == HALF_BIT) begin
				check_value(32'(o_serial_out), 32'(bits[cyc / CLKS_PER_BIT]),
					$sformatf("serial out in bit %0d", cyc / CLKS_PER_BIT));
			end
		end
		check_value(32'(o_busy), 32'd1, "busy in last stop cycle");
		tick();
		check_value(32'(o_busy), 32'd0, "busy after one frame");
		for (cyc = 0; cyc < FRAME_CLKS; cyc++) begin
			tick(); // window of one frame after busy fell
		end
		if (rx_count == 0) abort_run("no loopback word within one frame after busy fell");
		else check_word(exp_data, exp_perr, exp_serr);
	endtask

	task automatic run_external_step(input logic [DATA_W-1:0] data, input logic flip,
			input logic stop_bit, input logic [DATA_W-1:0] exp_data, input logic exp_perr,
			input logic exp_serr);
		logic [FRAME_BITS-1:0] bits;
		int                    k;
		bits       = build_frame(data, flip, stop_bit);
		i_loopback = 1'b0;
		for (k = 0; k < FRAME_BITS; k++) begin
			i_serial_in = bits[k]; // bit-banged at the nominal rate
			repeat (CLKS_PER_BIT) tick();
		end
		i_serial_in = 1'b1;
		wait_rx_word(FRAME_CLKS);
		check_word(exp_data, exp_perr, exp_serr);
	endtask

	task automatic run_glitch_step();
		i_loopback  = 1'b0;
		i_serial_in = 1'b0;
		repeat (GLITCH_CLKS) tick();
		i_serial_in = 1'b1;
		repeat (2 * FRAME_CLKS) tick();
		check_value(32'(rx_count), 32'd0, "words after a glitch");
	endtask

	initial begin
		int          fd;
		string       line;
		int          n_fields;
		logic [7:0]  mode;
		logic [7:0]  data;
		int          flip;
		int          stop_bit;
		logic [7:0]  exp_data;
		int          exp_perr;
		int          exp_serr;
		int          steps;
		int          i;
		i_send      = 1'b0;
		i_tx_data   = '0;
		i_loopback  = 1'b1;
		i_serial_in = 1'b1; // idle line
		reset       = 1'b1;
		rx_count    = 0;
		steps       = 0;
		for (i = 0; i < RESET_CLKS; i++) begin
			tick();
			check_idle_outputs("during reset");
		end
		reset = 1'b0;
		tick();
		check_idle_outputs("after reset");
		fd = $fopen("test/uart_trace.txt", "r");
		if (fd == 0) abort_run("cannot open test/uart_trace.txt");
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#") continue; // header and blank lines
			n_fields = $sscanf(line, "%c %h %d %d %h %d %d", mode, data, flip, stop_bit,
				exp_data, exp_perr, exp_serr);
			if (n_fields != 7) abort_run({"malformed trace line: ", line});
			check_value(32'(rx_count), 32'd0, "stray word before a step");
			case (mode)
				"L": run_loopback_step(data, exp_data, exp_perr != 0, exp_serr != 0);
				"E": run_external_step(data, flip != 0, stop_bit != 0, exp_data, exp_perr != 0,
					exp_serr != 0);
				"G": run_glitch_step();
				default: abort_run("unknown mode letter in the trace file");
			endcase
			steps++;
			repeat (int'(next_rand() % 32'd16)) tick(); // idle gap of 0 to 15 cycles
		end
		$fclose(fd);
		if (steps == 0) begin
			abort_run("the trace file holds no test steps");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

// ==== test/uart_trace.txt ====
# mode data parity_flip stop_bit | exp_data exp_parity_err exp_stop_err (data in hex)
# mode L loopback send, E external frame, G glitch of 3 cycles
L 55 0 1 55 0 0
L a3 0 1 a3 0 0
L 00 0 1 00 0 0
L ff 0 1 ff 0 0
E 3c 1 1 3c 1 0
E 81 0 0 81 0 1
L 5a 0 1 5a 0 0
G 00 0 1 00 0 0
L 01 0 1 01 0 0
E c7 1 0 c7 1 1
L 80 0 1 80 0 0
G 00 0 1 00 0 0
E 96 0 1 96 0 0
L 7e 0 1 7e 0 0
L 12 0 1 12 0 0
E 0f 1 1 0f 1 0
L e4 0 1 e4 0 0
G 00 0 1 00 0 0
E f0 0 0 f0 0 1
L 2d 0 1 2d 0 0
L 99 0 1 99 0 0
L 6b 0 1 6b 0 0
